//--- src/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Bus widths
`define CSR_ADDR_W      14
`define CSR_DATA_W      32
`define HW_INT_W        8

// Exception and status registers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c

// SAVE1..SAVE3 sit at the next three addresses
`define CSR_SAVE0       14'h030

// Constant timer
`define CSR_TID         14'h040
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

// Local interrupt enables, bit 10 reserved
`define ECFG_LIE_MASK   13'h1bff

`define TCFG_INITVAL_W  30

`endif

//--- src/csr_pkg.sv
`include "csr_params.svh"

package csr_pkg;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`CSR_DATA_W-1:0] csr_data_t;
    typedef logic [5:0]             ecode_t;
    typedef logic [8:0]             esubcode_t;
    typedef logic [1:0]             plv_t;

    typedef struct packed {
        logic [22:0] zero;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        plv_t        plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] zero;
        logic        pie;
        plv_t        pplv;
    } prmd_t;

    // IS field occupies bits 12:0
    typedef struct packed {
        logic                 rsv31;
        esubcode_t            esubcode;
        ecode_t               ecode;
        logic [2:0]           rsv15_13;
        logic                 is_ipi;
        logic                 is_ti;
        logic                 is_rsv;
        logic [`HW_INT_W-1:0] is_hw;
        logic [1:0]           is_sw;
    } estat_t;

    typedef struct packed {
        logic [`TCFG_INITVAL_W-1:0] initval;
        logic                       periodic;
        logic                       en;
    } tcfg_t;

    // One CSR word, decoded by the register it belongs to
    typedef union packed {
        csr_data_t raw;
        crmd_t     crmd;
        prmd_t     prmd;
        estat_t    estat;
        tcfg_t     tcfg;
    } csr_word_u;

endpackage

//--- src/csr_write_port.sv
`timescale 1ns/1ps

module csr_write_port (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               flush,
    input  logic               wr_valid,
    input  csr_pkg::csr_addr_t wr_addr,
    input  csr_pkg::csr_word_u wr_data,
    output logic               wr_ready,
    output logic               commit_valid,
    output csr_pkg::csr_addr_t commit_addr,
    output csr_pkg::csr_word_u commit_data
);
    import csr_pkg::*;

    logic      held;
    csr_addr_t held_addr;
    csr_word_u held_data;
    logic      accept;

    assign accept = wr_valid && wr_ready;

    // Single entry, so no new write while one is held
    assign wr_ready = ~held;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            held <= 1'b0;
        end else begin
            held <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_addr <= wr_addr;
            held_data <= wr_data;
        end
    end

    // Flush in the commit cycle drops the write
    assign commit_valid = held && !flush;
    assign commit_addr  = held_addr;
    assign commit_data  = held_data;

endmodule

//--- src/exc_state.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module exc_state (
    input  logic                       clk,
    input  logic                       aresetn,
    input  logic                       commit_valid,
    input  csr_pkg::csr_addr_t         commit_addr,
    input  csr_pkg::csr_word_u         commit_data,
    input  logic                       exc_valid,
    input  csr_pkg::ecode_t            exc_ecode,
    input  csr_pkg::esubcode_t         exc_esubcode,
    input  csr_pkg::csr_data_t         exc_era,
    input  logic                       exc_badv_valid,
    input  csr_pkg::csr_data_t         exc_badv,
    input  logic                       ertn,
    output csr_pkg::crmd_t             crmd,
    output csr_pkg::prmd_t             prmd,
    output logic [12:0]                ecfg_lie,
    output csr_pkg::estat_t            estat_sw,
    output csr_pkg::csr_data_t         era,
    output csr_pkg::csr_data_t         badv,
    output csr_pkg::csr_data_t         eentry,
    output csr_pkg::csr_data_t [3:0]   save_regs
);
    import csr_pkg::*;

    logic [1:0] is_sw_q;
    ecode_t     ecode_q;
    esubcode_t  esubcode_q;

    // Direct address mode, cached fetch and data
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd <= '{zero: '0, datm: 2'd1, datf: 2'd1, pg: 1'b0, da: 1'b1,
                      ie: 1'b0, plv: '0};
        end else if (ertn) begin
            crmd.plv <= prmd.pplv;
            crmd.ie  <= prmd.pie;
        end else if (exc_valid) begin
            crmd.plv <= '0;
            crmd.ie  <= 1'b0;
        end else if (commit_valid && commit_addr == `CSR_CRMD) begin
            crmd.plv  <= commit_data.crmd.plv;
            crmd.ie   <= commit_data.crmd.ie;
            crmd.datf <= commit_data.crmd.datf;
            crmd.datm <= commit_data.crmd.datm;
            // Only one of PG and DA may be set
            if (commit_data.crmd.pg ^ commit_data.crmd.da) begin
                crmd.pg <= commit_data.crmd.pg;
                crmd.da <= commit_data.crmd.da;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd <= '0;
        end else if (exc_valid) begin
            prmd.pplv <= crmd.plv;
            prmd.pie  <= crmd.ie;
        end else if (commit_valid && commit_addr == `CSR_PRMD) begin
            prmd.pplv <= commit_data.prmd.pplv;
            prmd.pie  <= commit_data.prmd.pie;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie <= '0;
        end else if (commit_valid && commit_addr == `CSR_ECFG) begin
            ecfg_lie <= commit_data.raw[12:0] & `ECFG_LIE_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            is_sw_q    <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else if (exc_valid) begin
            ecode_q    <= exc_ecode;
            esubcode_q <= (exc_ecode == '0) ? '0 : exc_esubcode;
        end else if (commit_valid && commit_addr == `CSR_ESTAT) begin
            is_sw_q <= commit_data.estat.is_sw;
        end
    end

    always_comb begin
        estat_sw          = '0;
        estat_sw.is_sw    = is_sw_q;
        estat_sw.ecode    = ecode_q;
        estat_sw.esubcode = esubcode_q;
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era <= '0;
        end else if (exc_valid) begin
            era <= exc_era;
        end else if (commit_valid && commit_addr == `CSR_ERA) begin
            era <= commit_data.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (exc_badv_valid) begin
            badv <= exc_badv;
        end else if (commit_valid && commit_addr == `CSR_BADV) begin
            badv <= commit_data.raw;
        end
    end

    // Entry point is 64-byte aligned
    always_ff @(posedge clk) begin
        if (commit_valid && commit_addr == `CSR_EENTRY) begin
            eentry <= {commit_data.raw[31:6], 6'b0};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (commit_valid && commit_addr == `CSR_SAVE0 + i) begin
                save_regs[i] <= commit_data.raw;
            end
        end
    end

endmodule

//--- src/timer_unit.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module timer_unit (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit_valid,
    input  csr_pkg::csr_addr_t commit_addr,
    input  csr_pkg::csr_word_u commit_data,
    output csr_pkg::csr_data_t tid,
    output csr_pkg::tcfg_t     tcfg,
    output csr_pkg::csr_data_t tval,
    output logic               ti_pending
);
    import csr_pkg::*;

    localparam int PAD_W = `CSR_DATA_W - `TCFG_INITVAL_W;

    logic tcfg_load;
    logic expire;
    logic ticlr;

    assign tcfg_load = commit_valid && commit_addr == `CSR_TCFG;
    assign ticlr     = commit_valid && commit_addr == `CSR_TICLR && commit_data.raw[0];

    // Counter steps 1 -> 0 on this edge
    assign expire = tcfg.en && !tcfg_load && tval == 32'd1;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tid <= '0;
        end else if (commit_valid && commit_addr == `CSR_TID) begin
            tid <= commit_data.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg <= '0;
        end else if (tcfg_load) begin
            tcfg <= commit_data.tcfg;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval <= '0;
        end else if (tcfg_load) begin
            tval <= {{PAD_W{1'b0}}, commit_data.tcfg.initval};
        end else if (tcfg.en) begin
            if (tval != '0) begin
                tval <= tval - 32'd1;
            end else if (tcfg.periodic) begin
                tval <= {{PAD_W{1'b0}}, tcfg.initval};
            end
        end
    end

    // New expiry wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ti_pending <= 1'b0;
        end else if (expire) begin
            ti_pending <= 1'b1;
        end else if (ticlr) begin
            ti_pending <= 1'b0;
        end
    end

endmodule

//--- src/csr_readout_irq.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_readout_irq (
    input  csr_pkg::csr_addr_t       rd_addr,
    input  logic [`HW_INT_W-1:0]     hw_int,
    input  csr_pkg::crmd_t           crmd,
    input  csr_pkg::prmd_t           prmd,
    input  logic [12:0]              ecfg_lie,
    input  csr_pkg::estat_t          estat_sw,
    input  csr_pkg::csr_data_t       era,
    input  csr_pkg::csr_data_t       badv,
    input  csr_pkg::csr_data_t       eentry,
    input  csr_pkg::csr_data_t [3:0] save_regs,
    input  csr_pkg::csr_data_t       tid,
    input  csr_pkg::tcfg_t           tcfg,
    input  csr_pkg::csr_data_t       tval,
    input  logic                     ti_pending,
    output csr_pkg::csr_word_u       rd_data,
    output logic                     irq
);
    import csr_pkg::*;

    estat_t      estat;
    logic [12:0] is_bits;

    // Live interrupt lines merged into the stored fields
    always_comb begin
        estat       = estat_sw;
        estat.is_hw = hw_int;
        estat.is_ti = ti_pending;
    end

    assign is_bits = {estat.is_ipi, estat.is_ti, estat.is_rsv, estat.is_hw, estat.is_sw};

    // TICLR is write-only and falls to the default
    always_comb begin
        rd_data = '0;
        case (rd_addr)
            `CSR_CRMD:          rd_data.crmd  = crmd;
            `CSR_PRMD:          rd_data.prmd  = prmd;
            `CSR_ECFG:          rd_data.raw   = {{(`CSR_DATA_W-13){1'b0}}, ecfg_lie};
            `CSR_ESTAT:         rd_data.estat = estat;
            `CSR_ERA:           rd_data.raw   = era;
            `CSR_BADV:          rd_data.raw   = badv;
            `CSR_EENTRY:        rd_data.raw   = eentry;
            `CSR_SAVE0:         rd_data.raw   = save_regs[0];
            `CSR_SAVE0 + 14'd1: rd_data.raw   = save_regs[1];
            `CSR_SAVE0 + 14'd2: rd_data.raw   = save_regs[2];
            `CSR_SAVE0 + 14'd3: rd_data.raw   = save_regs[3];
            `CSR_TID:           rd_data.raw   = tid;
            `CSR_TCFG:          rd_data.tcfg  = tcfg;
            `CSR_TVAL:          rd_data.raw   = tval;
            default:            rd_data.raw   = '0;
        endcase
    end

    assign irq = crmd.ie && |(is_bits & ecfg_lie);

endmodule

//--- src/csr_top.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_top (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 wr_valid,
    input  csr_pkg::csr_addr_t   wr_addr,
    input  csr_pkg::csr_word_u   wr_data,
    input  logic                 flush,
    input  csr_pkg::csr_addr_t   rd_addr,
    input  logic                 exc_valid,
    input  csr_pkg::ecode_t      exc_ecode,
    input  csr_pkg::esubcode_t   exc_esubcode,
    input  csr_pkg::csr_data_t   exc_era,
    input  logic                 exc_badv_valid,
    input  csr_pkg::csr_data_t   exc_badv,
    input  logic                 ertn,
    input  logic [`HW_INT_W-1:0] hw_int,
    output logic                 wr_ready,
    output csr_pkg::csr_word_u   rd_data,
    output logic                 irq,
    output csr_pkg::crmd_t       crmd_out,
    output csr_pkg::csr_data_t   era_out,
    output csr_pkg::csr_data_t   eentry_out
);

    logic                     commit_valid;
    csr_pkg::csr_addr_t       commit_addr;
    csr_pkg::csr_word_u       commit_data;
    csr_pkg::prmd_t           prmd;
    logic [12:0]              ecfg_lie;
    csr_pkg::estat_t          estat_sw;
    csr_pkg::csr_data_t       badv;
    csr_pkg::csr_data_t [3:0] save_regs;
    csr_pkg::csr_data_t       tid;
    csr_pkg::tcfg_t           tcfg;
    csr_pkg::csr_data_t       tval;
    logic                     ti_pending;

    csr_write_port write_port_i (
        .clk          (clk),
        .aresetn      (aresetn),
        .flush        (flush),
        .wr_valid     (wr_valid),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_ready     (wr_ready),
        .commit_valid (commit_valid),
        .commit_addr  (commit_addr),
        .commit_data  (commit_data)
    );

    exc_state exc_state_i (
        .clk            (clk),
        .aresetn        (aresetn),
        .commit_valid   (commit_valid),
        .commit_addr    (commit_addr),
        .commit_data    (commit_data),
        .exc_valid      (exc_valid),
        .exc_ecode      (exc_ecode),
        .exc_esubcode   (exc_esubcode),
        .exc_era        (exc_era),
        .exc_badv_valid (exc_badv_valid),
        .exc_badv       (exc_badv),
        .ertn           (ertn),
        .crmd           (crmd_out),
        .prmd           (prmd),
        .ecfg_lie       (ecfg_lie),
        .estat_sw       (estat_sw),
        .era            (era_out),
        .badv           (badv),
        .eentry         (eentry_out),
        .save_regs      (save_regs)
    );

    timer_unit timer_i (
        .clk          (clk),
        .aresetn      (aresetn),
        .commit_valid (commit_valid),
        .commit_addr  (commit_addr),
        .commit_data  (commit_data),
        .tid          (tid),
        .tcfg         (tcfg),
        .tval         (tval),
        .ti_pending   (ti_pending)
    );

    csr_readout_irq readout_i (
        .rd_addr    (rd_addr),
        .hw_int     (hw_int),
        .crmd       (crmd_out),
        .prmd       (prmd),
        .ecfg_lie   (ecfg_lie),
        .estat_sw   (estat_sw),
        .era        (era_out),
        .badv       (badv),
        .eentry     (eentry_out),
        .save_regs  (save_regs),
        .tid        (tid),
        .tcfg       (tcfg),
        .tval       (tval),
        .ti_pending (ti_pending),
        .rd_data    (rd_data),
        .irq        (irq)
    );

endmodule

//--- sim/csr_tb.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_tb;
    import csr_pkg::*;

    // Rough length of all directed tests, plus the longest timer wait
    localparam int TEST_CYCLES    = 300;
    localparam int TIMER_WAIT_MAX = 14;
    localparam int CYCLE_LIMIT    = TEST_CYCLES + TIMER_WAIT_MAX + 100;

    logic                 clk;
    logic                 aresetn;
    logic                 wr_valid;
    logic                 flush;
    logic                 exc_valid;
    logic                 exc_badv_valid;
    logic                 ertn;
    logic                 wr_ready;
    logic                 irq;
    csr_addr_t            wr_addr;
    csr_addr_t            rd_addr;
    csr_word_u            wr_data;
    csr_word_u            rd_data;
    ecode_t               exc_ecode;
    esubcode_t            exc_esubcode;
    csr_data_t            exc_era;
    csr_data_t            exc_badv;
    csr_data_t            era_out;
    csr_data_t            eentry_out;
    crmd_t                crmd_out;
    logic [`HW_INT_W-1:0] hw_int;

    logic [31:0] lfsr_state = 32'h76b3;
    int          value_errors = 0;
    int          wait_errors = 0;
    int          cycle_count = 0;

    csr_top dut_i (
        .clk            (clk),
        .aresetn        (aresetn),
        .wr_valid       (wr_valid),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .flush          (flush),
        .rd_addr        (rd_addr),
        .exc_valid      (exc_valid),
        .exc_ecode      (exc_ecode),
        .exc_esubcode   (exc_esubcode),
        .exc_era        (exc_era),
        .exc_badv_valid (exc_badv_valid),
        .exc_badv       (exc_badv),
        .ertn           (ertn),
        .hw_int         (hw_int),
        .wr_ready       (wr_ready),
        .rd_data        (rd_data),
        .irq            (irq),
        .crmd_out       (crmd_out),
        .era_out        (era_out),
        .eentry_out     (eentry_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // CRMD word with DATF = DATM = 1
    function automatic csr_word_u make_crmd(input plv_t plv, input logic ie,
                                            input logic pg, input logic da);
        csr_word_u w;
        w.crmd = '{zero: '0, datm: 2'd1, datf: 2'd1, pg: pg, da: da, ie: ie, plv: plv};
        return w;
    endfunction

    task automatic check_word(input string name, input csr_word_u got, input csr_word_u exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got.raw, exp.raw);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic csr_write(input csr_addr_t addr, input csr_word_u data);
        int waited;
        waited = 0;
        while (!wr_ready && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!wr_ready) begin
            $display("Write port never became ready for address 0x%0h", addr);
            wait_errors++;
        end
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        @(negedge clk);
        wr_valid = 1'b0;
        check_bit("wr_ready", wr_ready, 1'b0);
    endtask

    task automatic csr_read(input csr_addr_t addr, output csr_word_u data);
        rd_addr = addr;
        @(negedge clk);
        data = rd_data;
    endtask

    task automatic reset_values();
        csr_word_u rd;
        csr_word_u zero;
        zero.raw = '0;
        csr_read(`CSR_CRMD, rd);
        check_word("CRMD", rd, make_crmd(2'd0, 1'b0, 1'b0, 1'b1));
        csr_read(`CSR_PRMD, rd);
        check_word("PRMD", rd, zero);
        csr_read(`CSR_ESTAT, rd);
        check_word("ESTAT", rd, zero);
        csr_read(`CSR_ERA, rd);
        check_word("ERA", rd, zero);
        csr_read(`CSR_TID, rd);
        check_word("TID", rd, zero);
        csr_read(`CSR_TCFG, rd);
        check_word("TCFG", rd, zero);
        csr_read(`CSR_TVAL, rd);
        check_word("TVAL", rd, zero);
        check_bit("irq", irq, 1'b0);
        check_bit("wr_ready", wr_ready, 1'b1);
    endtask

    task automatic write_readback();
        csr_word_u w;
        csr_word_u rd;
        csr_word_u exp;
        csr_word_u port;
        for (int i = 0; i < 4; i++) begin
            w.raw = rand_bits(32);
            csr_write(csr_addr_t'(`CSR_SAVE0 + i), w);
            csr_read(csr_addr_t'(`CSR_SAVE0 + i), rd);
            check_word($sformatf("SAVE%0d", i), rd, w);
        end
        w.raw = rand_bits(32);
        csr_write(`CSR_TID, w);
        csr_read(`CSR_TID, rd);
        check_word("TID", rd, w);
        w.raw = rand_bits(32);
        exp.raw = {w.raw[31:6], 6'b0};
        csr_write(`CSR_EENTRY, w);
        csr_read(`CSR_EENTRY, rd);
        check_word("EENTRY", rd, exp);
        port.raw = eentry_out;
        check_word("eentry_out", port, exp);
        w.raw = rand_bits(32);
        exp.raw = {19'b0, w.raw[12:0] & `ECFG_LIE_MASK};
        csr_write(`CSR_ECFG, w);
        csr_read(`CSR_ECFG, rd);
        check_word("ECFG", rd, exp);
        // PG and DA both set is not a legal mode
        w = make_crmd(2'(rand_bits(2)), 1'(rand_bits(1)), 1'b1, 1'b1);
        exp = make_crmd(w.crmd.plv, w.crmd.ie, 1'b0, 1'b1);
        csr_write(`CSR_CRMD, w);
        csr_read(`CSR_CRMD, rd);
        check_word("CRMD", rd, exp);
    endtask

    task automatic exception_round_trip();
        csr_word_u rd;
        csr_word_u exp;
        csr_word_u port;
        ecode_t    code;
        esubcode_t sub;
        csr_data_t era_v;
        csr_data_t badv_v;
        code   = 6'(rand_bits(5)) + 6'd1;
        sub    = 9'(rand_bits(9));
        era_v  = rand_bits(32);
        badv_v = rand_bits(32);
        csr_write(`CSR_CRMD, make_crmd(2'd3, 1'b1, 1'b0, 1'b1));
        @(negedge clk);
        exc_valid      = 1'b1;
        exc_ecode      = code;
        exc_esubcode   = sub;
        exc_era        = era_v;
        exc_badv_valid = 1'b1;
        exc_badv       = badv_v;
        @(negedge clk);
        exc_valid      = 1'b0;
        exc_badv_valid = 1'b0;
        exp.raw = '0;
        exp.prmd.pplv = 2'd3;
        exp.prmd.pie  = 1'b1;
        csr_read(`CSR_PRMD, rd);
        check_word("PRMD", rd, exp);
        csr_read(`CSR_CRMD, rd);
        check_word("CRMD", rd, make_crmd(2'd0, 1'b0, 1'b0, 1'b1));
        port.crmd = crmd_out;
        check_word("crmd_out", port, make_crmd(2'd0, 1'b0, 1'b0, 1'b1));
        exp.raw = '0;
        exp.estat.ecode    = code;
        exp.estat.esubcode = sub;
        csr_read(`CSR_ESTAT, rd);
        check_word("ESTAT", rd, exp);
        exp.raw = era_v;
        csr_read(`CSR_ERA, rd);
        check_word("ERA", rd, exp);
        port.raw = era_out;
        check_word("era_out", port, exp);
        exp.raw = badv_v;
        csr_read(`CSR_BADV, rd);
        check_word("BADV", rd, exp);
        ertn = 1'b1;
        @(negedge clk);
        ertn = 1'b0;
        csr_read(`CSR_CRMD, rd);
        check_word("CRMD after ERTN", rd, make_crmd(2'd3, 1'b1, 1'b0, 1'b1));
        port.crmd = crmd_out;
        check_word("crmd_out after ERTN", port, make_crmd(2'd3, 1'b1, 1'b0, 1'b1));
        // Zero ecode carries no subcode
        exc_valid    = 1'b1;
        exc_ecode    = '0;
        exc_esubcode = sub | 9'h1;
        @(negedge clk);
        exc_valid = 1'b0;
        exp.raw = '0;
        csr_read(`CSR_ESTAT, rd);
        check_word("ESTAT zero ecode", rd, exp);
    endtask

    task automatic oneshot_timer();
        csr_word_u w;
        csr_word_u rd;
        csr_word_u zero;
        int        init_cyc;
        int        waited;
        zero.raw = '0;
        init_cyc = 3 + int'(rand_bits(3));
        w.raw = 32'h0000_0800;
        csr_write(`CSR_ECFG, w);
        csr_write(`CSR_CRMD, make_crmd(2'd0, 1'b1, 1'b0, 1'b1));
        w.raw = '0;
        w.tcfg.initval  = 30'(init_cyc);
        w.tcfg.periodic = 1'b0;
        w.tcfg.en       = 1'b1;
        csr_write(`CSR_TCFG, w);
        waited = 0;
        while (!irq && waited < init_cyc + 4) begin
            @(negedge clk);
            waited++;
        end
        if (!irq) begin
            $display("Timer interrupt did not rise within %0d cycles", init_cyc + 4);
            wait_errors++;
        end
        csr_read(`CSR_ESTAT, rd);
        check_bit("ESTAT.IS[11]", rd.estat.is_ti, 1'b1);
        w.raw = 32'h1;
        csr_write(`CSR_TICLR, w);
        csr_read(`CSR_TVAL, rd);
        check_word("TVAL", rd, zero);
        check_bit("irq", irq, 1'b0);
        repeat (3) @(negedge clk);
        csr_read(`CSR_TVAL, rd);
        check_word("TVAL", rd, zero);
    endtask

    task automatic hw_interrupts();
        csr_word_u   w;
        csr_word_u   rd;
        csr_word_u   exp;
        logic [12:0] lie;
        logic        ie;
        logic [7:0]  hw;
        for (int i = 0; i < 6; i++) begin
            lie = 13'(rand_bits(13));
            ie  = 1'(rand_bits(1));
            hw  = 8'(rand_bits(8));
            w.raw = {19'b0, lie};
            csr_write(`CSR_ECFG, w);
            csr_write(`CSR_CRMD, make_crmd(2'd0, ie, 1'b0, 1'b1));
            hw_int = hw;
            csr_read(`CSR_ESTAT, rd);
            rd.raw  = rd.raw & 32'h0000_03fc;
            exp.raw = {22'b0, hw, 2'b0};
            check_word("ESTAT.IS_HW", rd, exp);
            check_bit("irq", irq, ie && |(hw & lie[9:2]));
        end
        hw_int = '0;
    endtask

    task automatic flush_drops_write();
        csr_word_u w_old;
        csr_word_u w_new;
        csr_word_u rd;
        w_old.raw = rand_bits(32);
        w_new.raw = rand_bits(32);
        csr_write(csr_addr_t'(`CSR_SAVE0 + 1), w_old);
        csr_read(csr_addr_t'(`CSR_SAVE0 + 1), rd);
        check_word("SAVE1", rd, w_old);
        csr_write(csr_addr_t'(`CSR_SAVE0 + 1), w_new);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        csr_read(csr_addr_t'(`CSR_SAVE0 + 1), rd);
        check_word("SAVE1 after flush", rd, w_old);
        check_bit("wr_ready", wr_ready, 1'b1);
    endtask

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing the tests", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        aresetn        = 1'b0;
        wr_valid       = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        flush          = 1'b0;
        rd_addr        = '0;
        exc_valid      = 1'b0;
        exc_ecode      = '0;
        exc_esubcode   = '0;
        exc_era        = '0;
        exc_badv_valid = 1'b0;
        exc_badv       = '0;
        ertn           = 1'b0;
        hw_int         = '0;
        repeat (10) @(negedge clk);
        aresetn = 1'b1;
        @(negedge clk);
        reset_values();
        write_readback();
        exception_round_trip();
        oneshot_timer();
        hw_interrupts();
        flush_drops_write();
        $display("Checks done: %0d value mismatches, %0d wait failures",
                 value_errors, wait_errors);
        if (value_errors == 0 && wait_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+src
src/csr_pkg.sv
src/csr_write_port.sv
src/exc_state.sv
src/timer_unit.sv
src/csr_readout_irq.sv
src/csr_top.sv
sim/csr_tb.sv
